// File: compile.f
+incdir+tb
verilog/runner_pkg.sv
verilog/obstacle_picker.sv
verilog/track_scroller.sv
verilog/runner_motion.sv
verilog/score_display.sv
verilog/runner_game.sv
tb/runner_game_tb.sv

// File: tb/runner_model.svh
// Height order of the kinds, a hole counts as flat ground
function automatic int terrain_level(terrain_t kind);
	case (kind)
		one_block:   return 1;
		two_block:   return 2;
		three_block: return 3;
		default:     return 0;
	endcase
endfunction

// Kinds the transition table may pick after prev then cur
function automatic bit kind_legal(terrain_t prev, terrain_t cur, terrain_t kind);
	if (int'(kind) > int'(hole))
		return 1'b0;
	case (cur)
		ground:    return kind inside {ground, one_block, hole};
		one_block: return kind != three_block;
		hole:      return kind != hole && terrain_level(kind) <= terrain_level(prev);
		default:   return 1'b1;   // Blocks of two or three may go anywhere
	endcase
endfunction

function automatic coord_y_t kind_height(terrain_t kind);
	case (kind)
		one_block:   return 7'd79;
		two_block:   return 7'd59;
		three_block: return 7'd39;
		hole:        return 7'd119;
		default:     return 7'd100;
	endcase
endfunction

// One frame of runner physics
function automatic runner_state_t runner_step(runner_state_t r, coord_y_t gnd, bit pressed);
	runner_state_t n;
	int            y;
	int            x;
	n = r;
	y = r.char_y;
	x = r.runner_x;
	if ((r.jumping || pressed) && r.jump_count < JUMP_LIMIT)
	begin
		n.jump_count = r.jump_count + JUMP_STEP;
		n.jumping    = 1'b1;
		y            = y - RISE_STEP;
	end
	else
	begin
		n.jump_count = '0;
		n.jumping    = 1'b0;
	end
	if (y < gnd - 1)
		y = y + FALL_STEP;
	if (y > gnd)   // Terrain in the way
	begin
		if (x > 0)
			x = x - 1;
	end
	else if (x < RUNNER_X)
		x = x + 1;
	// Off the left edge or on the hole floor
	if (x == 0 || y >= HEIGHT_HOLE)
		n.dead = 1'b1;
	n.char_y   = coord_y_t'(y);
	n.runner_x = coord_x_t'(x);
	return n;
endfunction

function automatic bcd_score_t score_bcd(int count);
	bcd_score_t s;
	s.one       = 4'((count) % 10);
	s.ten       = 4'((count / 10) % 10);
	s.hund      = 4'((count / 100) % 10);
	s.thou      = 4'((count / 1000) % 10);
	s.ten_thou  = 4'((count / 10000) % 10);
	s.hund_thou = 4'((count / 100000) % 10);
	return s;
endfunction

// Active low segments g down to a
function automatic logic [6:0] seg_pattern(logic [3:0] digit);
	case (digit)
		4'd0:    return 7'h40;
		4'd1:    return 7'h79;
		4'd2:    return 7'h24;
		4'd3:    return 7'h30;
		4'd4:    return 7'h19;
		4'd5:    return 7'h12;
		4'd6:    return 7'h02;
		4'd7:    return 7'h78;
		4'd8:    return 7'h00;
		4'd9:    return 7'h18;
		default: return 7'h7f;
	endcase
endfunction

function automatic hex_display_t hex_ref(bcd_score_t s);
	hex_display_t h;
	h.hex0 = seg_pattern(s.one);
	h.hex1 = seg_pattern(s.ten);
	h.hex2 = seg_pattern(s.hund);
	h.hex3 = seg_pattern(s.thou);
	h.hex4 = seg_pattern(s.ten_thou);
	h.hex5 = seg_pattern(s.hund_thou);
	return h;
endfunction

task automatic check_runner(string name, runner_state_t got, runner_state_t exp);
	if (got !== exp)
	begin
		$display("FAILED %s: got %h, expected %h", name, got, exp);
		abort_run();
	end
endtask

task automatic check_spawn(string name, spawn_t got, spawn_t exp);
	if (got !== exp)
	begin
		$display("FAILED %s: got %h, expected %h", name, got, exp);
		abort_run();
	end
endtask

task automatic check_score(string name, bcd_score_t got, bcd_score_t exp);
	if (got !== exp)
	begin
		$display("FAILED %s: got %h, expected %h", name, got, exp);
		abort_run();
	end
endtask

task automatic check_hex(string name, hex_display_t got, hex_display_t exp);
	if (got !== exp)
	begin
		$display("FAILED %s: got %h, expected %h", name, got, exp);
		abort_run();
	end
endtask

task automatic check_row(string name, coord_y_t got, coord_y_t exp);
	if (got !== exp)
	begin
		$display("FAILED %s: got %h, expected %h", name, got, exp);
		abort_run();
	end
endtask

task automatic check_bit(string name, logic got, logic exp);
	if (got !== exp)
	begin
		$display("FAILED %s: got %h, expected %h", name, got, exp);
		abort_run();
	end
endtask

// File: tb/runner_game_tb.sv
`timescale 1ns/10ps

module runner_game_tb
	import runner_pkg::*;
();

	localparam int DEATH_TIMEOUT = 1000 * FRAME_TICKS;   // Cycles

	logic          CLOCK_50;
	logic          resetn;
	logic          key_start;
	logic          key_jump;
	logic          frame_done;
	logic          running;
	runner_state_t runner;
	spawn_t        spawn;
	coord_y_t      ground_y;
	bcd_score_t    score;
	hex_display_t  hex;

	// Reference model state
	runner_state_t exp_runner;
	spawn_t        exp_spawn;
	coord_y_t      last_ground;
	int            slot_col [NUM_SLOTS];
	coord_y_t      slot_row [NUM_SLOTS];
	terrain_t      cur_kind;
	terrain_t      prev_kind;
	int            spawn_count = 0;
	int            frames = 0;
	bit            jump_seen = 1'b0;   // Key low at some edge of this frame
	bit            dead_seen = 1'b0;
	integer        seed;

	`include "runner_model.svh"

	runner_game runner_game_i (
		.CLOCK_50   (CLOCK_50),
		.resetn     (resetn),
		.key_start  (key_start),
		.key_jump   (key_jump),
		.frame_done (frame_done),
		.running    (running),
		.runner     (runner),
		.spawn      (spawn),
		.ground_y   (ground_y),
		.score      (score),
		.hex        (hex)
	);

	initial
	begin
		CLOCK_50 = 1'b0;
		forever
			#50 CLOCK_50 = ~CLOCK_50;
	end

	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1, "Run stopped at the first error");
	endtask

	// Height of the first slot whose span holds the column, plain ground in gaps
	function automatic coord_y_t ground_under(int col);
		int       i;
		coord_y_t gnd;
		bit       found;
		gnd   = HEIGHT_GROUND;
		found = 1'b0;
		for (i = 0; i < NUM_SLOTS; i++)
		begin
			if (!found && col >= slot_col[i] && col < slot_col[i] + SLOT_SPACING)
			begin
				gnd   = slot_row[i];
				found = 1'b1;
			end
		end
		return gnd;
	endfunction

	task automatic reset_model();
		int i;
		exp_runner = '{char_y: START_Y, runner_x: RUNNER_X, jump_count: 5'd0,
			jumping: 1'b0, dead: 1'b0};
		for (i = 0; i < NUM_SLOTS; i++)
		begin
			slot_col[i] = i * SLOT_SPACING;
			slot_row[i] = HEIGHT_GROUND;
		end
		cur_kind    = ground;
		prev_kind   = ground;
		exp_spawn   = '0;
		spawn_count = 0;
		jump_seen   = 1'b0;
		dead_seen   = 1'b0;
		last_ground = ground_under(RUNNER_X);
	endtask

	// Compare one frame's results against the model
	task automatic check_frame();
		int       i;
		int       hit;
		coord_y_t exp_ground;
		hit        = -1;
		exp_runner = runner_step(exp_runner, last_ground, jump_seen);
		jump_seen  = 1'b0;
		check_runner("runner", runner, exp_runner);
		for (i = 0; i < NUM_SLOTS; i++)
			if (slot_col[i] == 0 && hit < 0)
				hit = i;
		for (i = 0; i < NUM_SLOTS; i++)
		begin
			if (i == hit)
				slot_col[i] = SPAWN_X;
			else if (slot_col[i] != 0)
				slot_col[i] = slot_col[i] - 1;   // Scroll left
		end
		exp_spawn.spawned = (hit >= 0);
		if (hit >= 0)
		begin
			if (!kind_legal(prev_kind, cur_kind, spawn.kind))
			begin
				$display("Illegal terrain kind %0d spawned after kinds %0d and %0d",
					spawn.kind, prev_kind, cur_kind);
				abort_run();
			end
			exp_spawn.kind   = spawn.kind;
			exp_spawn.height = kind_height(spawn.kind);
			slot_row[hit]    = kind_height(spawn.kind);
			prev_kind        = cur_kind;
			cur_kind         = spawn.kind;
			spawn_count++;
		end
		check_spawn("spawn", spawn, exp_spawn);
		check_score("score", score, score_bcd(spawn_count));
		check_hex("hex", hex, hex_ref(score_bcd(spawn_count)));
		exp_ground = ground_under(exp_runner.runner_x);
		check_row("ground_y", ground_y, exp_ground);
		last_ground = exp_ground;
		frames++;
		if (exp_runner.dead)
			dead_seen = 1'b1;
	endtask

	// Key sampled at each edge, results checked mid cycle
	initial
	begin
		forever
		begin
			@(posedge CLOCK_50);
			if (!key_jump)
				jump_seen = 1'b1;
			@(negedge CLOCK_50);
			if (frame_done)
				check_frame();
		end
	end

	task automatic start_game();
		int cycles;
		cycles = 0;
		@(posedge CLOCK_50);
		#10 key_start = 1'b0;
		do
		begin
			@(posedge CLOCK_50);
			#10 cycles++;
			if (cycles > 4)
			begin
				$display("Timeout: the game did not start after the start key was pressed");
				abort_run();
			end
		end while (!running);
		key_start = 1'b1;
		@(posedge CLOCK_50);   // new_game clears everything here
		#10 reset_model();
		check_runner("runner", runner, exp_runner);
		check_spawn("spawn", spawn, '0);
		check_row("ground_y", ground_y, HEIGHT_GROUND);
		check_score("score", score, '0);
		check_hex("hex", hex, hex_ref('0));
	endtask

	task automatic play_until_dead();
		int cycles;
		cycles = 0;
		while (!dead_seen)
		begin
			@(posedge CLOCK_50);
			#10 key_jump = (($random(seed) & 15) != 0);
			cycles++;
			if (cycles > DEATH_TIMEOUT)
			begin
				$display("Timeout: the runner was still alive after %0d cycles", cycles);
				abort_run();
			end
		end
		key_jump = 1'b1;
	endtask

	task automatic play_frames(int count);
		int cycles;
		int target;
		cycles = 0;
		target = frames + count;
		while (frames < target)
		begin
			@(posedge CLOCK_50);
			#10 key_jump = (($random(seed) & 15) != 0);
			cycles++;
			if (cycles > (count + 2) * FRAME_TICKS)
			begin
				$display("Timeout: frames stopped arriving after the restart");
				abort_run();
			end
		end
		key_jump = 1'b1;
	endtask

	initial
	begin
		seed      = 32'h55f7ace4;
		resetn    = 1'b0;
		key_start = 1'b1;
		key_jump  = 1'b1;
		repeat (3) @(posedge CLOCK_50);
		#10 resetn = 1'b1;

		// Nothing moves before start
		repeat (50)
		begin
			@(negedge CLOCK_50);
			check_bit("running", running, 1'b0);
			check_bit("frame_done", frame_done, 1'b0);
			check_bit("spawn.spawned", spawn.spawned, 1'b0);
			check_bit("runner.dead", runner.dead, 1'b0);
		end
		check_score("score", score, '0);
		check_hex("hex", hex, hex_ref('0));

		start_game();
		play_until_dead();

		// Frames stay stopped in the over state
		repeat (5 * FRAME_TICKS)
		begin
			@(negedge CLOCK_50);
			check_bit("running", running, 1'b0);
			check_bit("frame_done", frame_done, 1'b0);
		end

		start_game();
		play_frames(40);

		$display(">>> PASS");
		$finish;
	end

endmodule

// File: verilog/runner_game.sv
`timescale 1ns/10ps

module runner_game
	import runner_pkg::*;
(
	input  logic          CLOCK_50,
	input  logic          resetn,
	input  logic          key_start,
	input  logic          key_jump,
	output logic          frame_done,
	output logic          running,
	output runner_state_t runner,
	output spawn_t        spawn,
	output coord_y_t      ground_y,
	output bcd_score_t    score,
	output hex_display_t  hex
);

	typedef enum logic [1:0] {idle, run, over} game_state_t;

	game_state_t                    state;
	logic [$clog2(FRAME_TICKS)-1:0] frame_cnt;
	logic                           new_game;
	logic                           frame_tick;
	logic                           spawn_take;
	terrain_t                       next_kind;
	terrain_t                       placed_kind;

	assign running    = (state == run);
	assign frame_tick = running && !new_game &&
		frame_cnt == $bits(frame_cnt)'(FRAME_TICKS - 1);

	always_ff @(posedge CLOCK_50)
	begin
		if (!resetn)
		begin
			state      <= idle;
			new_game   <= 1'b0;
			frame_cnt  <= '0;
			frame_done <= 1'b0;
		end
		else
		begin
			new_game   <= 1'b0;
			frame_done <= frame_tick;   // Results are settled one cycle after the tick
			case (state)
				idle, over:
					if (!key_start)
					begin
						state     <= run;
						new_game  <= 1'b1;
						frame_cnt <= '0;
					end
				run:
					// Dead flag is stale while the new game clears it
					if (runner.dead && !new_game)
						state <= over;
					else if (frame_tick)
						frame_cnt <= '0;
					else
						frame_cnt <= frame_cnt + 1'b1;
				default: state <= idle;
			endcase
		end
	end

	obstacle_picker picker_i (
		.CLOCK_50    (CLOCK_50),
		.resetn      (resetn),
		.new_game    (new_game),
		.spawn_take  (spawn_take),
		.placed_kind (placed_kind),
		.next_kind   (next_kind)
	);

	track_scroller track_i (
		.CLOCK_50    (CLOCK_50),
		.resetn      (resetn),
		.frame_tick  (frame_tick),
		.new_game    (new_game),
		.next_kind   (next_kind),
		.runner_x    (runner.runner_x),
		.ground_y    (ground_y),
		.spawn       (spawn),
		.spawn_take  (spawn_take),
		.placed_kind (placed_kind)
	);

	runner_motion motion_i (
		.CLOCK_50   (CLOCK_50),
		.resetn     (resetn),
		.frame_tick (frame_tick),
		.new_game   (new_game),
		.key_jump   (key_jump),
		.ground_y   (ground_y),
		.runner     (runner)
	);

	score_display score_i (
		.CLOCK_50   (CLOCK_50),
		.resetn     (resetn),
		.frame_tick (frame_tick),
		.new_game   (new_game),
		.spawn      (spawn),
		.score      (score),
		.hex        (hex)
	);

endmodule

// File: verilog/score_display.sv
`timescale 1ns/10ps

module score_display
	import runner_pkg::*;
(
	input  logic         CLOCK_50,
	input  logic         resetn,
	input  logic         frame_tick,
	input  logic         new_game,
	input  spawn_t       spawn,
	output bcd_score_t   score,
	output hex_display_t hex
);

	bcd_score_t      count_q;    // Spawns of the frames before this one
	logic [5:0][3:0] digits_q;
	logic [5:0][3:0] digits_inc;
	logic [5:0][3:0] digits;
	logic [5:0][6:0] segs;
	logic            carry;

	assign digits_q = count_q;

	// Decimal increment, ones first
	always_comb
	begin
		carry = 1'b1;
		for (int d = 0; d < 6; d++)
		begin
			if (carry && digits_q[d] == 4'd9)
				digits_inc[d] = 4'd0;
			else if (carry)
			begin
				digits_inc[d] = digits_q[d] + 4'd1;
				carry         = 1'b0;
			end
			else
				digits_inc[d] = digits_q[d];
		end
	end

	// This frame's spawn is already part of the shown score
	assign digits = spawn.spawned ? digits_inc : digits_q;
	assign score  = digits;

	always_ff @(posedge CLOCK_50)
	begin
		if (!resetn || new_game)
			count_q <= '0;
		else if (frame_tick)
			count_q <= score;
	end

	always_comb
	begin
		for (int d = 0; d < 6; d++)
			segs[d] = (digits[d] > 4'd9) ? 7'h7f : SEG_DIGITS[digits[d]];   // Blank if not BCD
	end

	assign hex = segs;

endmodule

// File: verilog/runner_motion.sv
`timescale 1ns/10ps

module runner_motion
	import runner_pkg::*;
(
	input  logic          CLOCK_50,
	input  logic          resetn,
	input  logic          frame_tick,
	input  logic          new_game,
	input  logic          key_jump,
	input  coord_y_t      ground_y,
	output runner_state_t runner
);

	runner_state_t nxt;
	logic          jump_req;   // Key seen since the last frame
	logic          jump_active;

	always_comb
	begin
		nxt         = runner;
		jump_active = runner.jumping || jump_req || !key_jump;

		if (jump_active && runner.jump_count < JUMP_LIMIT)
		begin
			nxt.jump_count = runner.jump_count + JUMP_STEP;
			nxt.char_y     = runner.char_y - RISE_STEP;
			nxt.jumping    = 1'b1;
		end
		else
		begin
			nxt.jump_count = '0;
			nxt.jumping    = 1'b0;
		end

		if (nxt.char_y < ground_y - 7'd1)
			nxt.char_y = nxt.char_y + FALL_STEP;   // Gravity

		// Blocked by terrain higher than the runner
		if (nxt.char_y > ground_y)
		begin
			if (nxt.runner_x != '0)
				nxt.runner_x = nxt.runner_x - 8'd1;
		end
		else if (nxt.runner_x < RUNNER_X)
			nxt.runner_x = nxt.runner_x + 8'd1;

		// Pushed off the left edge or down on the hole floor
		if (nxt.runner_x == '0 || nxt.char_y >= HEIGHT_HOLE)
			nxt.dead = 1'b1;
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (!resetn || new_game)
		begin
			runner   <= '{char_y: START_Y, runner_x: RUNNER_X, jump_count: 5'd0,
				jumping: 1'b0, dead: 1'b0};
			jump_req <= 1'b0;
		end
		else if (frame_tick)
		begin
			runner   <= nxt;
			jump_req <= 1'b0;
		end
		else if (!key_jump && !runner.jumping)
			jump_req <= 1'b1;
	end

endmodule

// File: verilog/track_scroller.sv
`timescale 1ns/10ps

module track_scroller
	import runner_pkg::*;
(
	input  logic     CLOCK_50,
	input  logic     resetn,
	input  logic     frame_tick,
	input  logic     new_game,
	input  terrain_t next_kind,
	input  coord_x_t runner_x,
	output coord_y_t ground_y,
	output spawn_t   spawn,
	output logic     spawn_take,
	output terrain_t placed_kind
);

	coord_x_t slot_x [NUM_SLOTS];
	coord_y_t slot_y [NUM_SLOTS];

	logic                         respawn_hit;
	logic [$clog2(NUM_SLOTS)-1:0] respawn_idx;
	coord_y_t                     next_height;

	always_comb
	begin
		case (next_kind)
			one_block:   next_height = HEIGHT_ONE;
			two_block:   next_height = HEIGHT_TWO;
			three_block: next_height = HEIGHT_THREE;
			hole:        next_height = HEIGHT_HOLE;
			default:     next_height = HEIGHT_GROUND;
		endcase
	end

	// Lowest numbered slot at the left edge wins
	always_comb
	begin
		respawn_hit = 1'b0;
		respawn_idx = '0;
		for (int i = NUM_SLOTS - 1; i >= 0; i--)
		begin
			if (slot_x[i] == '0)
			begin
				respawn_hit = 1'b1;
				respawn_idx = $bits(respawn_idx)'(i);
			end
		end
	end

	assign spawn_take  = frame_tick && respawn_hit;
	assign placed_kind = next_kind;

	// Ground under the runner, plain ground in gaps between slots
	always_comb
	begin
		ground_y = HEIGHT_GROUND;
		for (int i = NUM_SLOTS - 1; i >= 0; i--)
		begin
			if ({1'b0, runner_x} >= {1'b0, slot_x[i]} &&
				{1'b0, runner_x} < {1'b0, slot_x[i]} + 9'(SLOT_SPACING))
				ground_y = slot_y[i];
		end
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (!resetn || new_game)
		begin
			for (int i = 0; i < NUM_SLOTS; i++)
			begin
				slot_x[i] <= coord_x_t'(i * SLOT_SPACING);
				slot_y[i] <= HEIGHT_GROUND;
			end
			spawn <= '0;
		end
		else if (frame_tick)
		begin
			for (int i = 0; i < NUM_SLOTS; i++)
			begin
				if (respawn_hit && respawn_idx == $bits(respawn_idx)'(i))
				begin
					slot_x[i] <= SPAWN_X;
					slot_y[i] <= next_height;
				end
				else if (slot_x[i] != '0)
					slot_x[i] <= slot_x[i] - 8'd1;   // Scroll left
			end
			spawn.spawned <= respawn_hit;
			if (respawn_hit)
			begin
				spawn.kind   <= next_kind;
				spawn.height <= next_height;
			end
		end
	end

endmodule

// File: verilog/obstacle_picker.sv
`timescale 1ns/10ps

module obstacle_picker
	import runner_pkg::*;
(
	input  logic     CLOCK_50,
	input  logic     resetn,
	input  logic     new_game,
	input  logic     spawn_take,
	input  terrain_t placed_kind,
	output terrain_t next_kind
);

	terrain_t   cur_kind;
	terrain_t   prev_kind;
	logic [2:0] choice;
	logic [2:0] choice_limit;

	// Number of choices depends on what is on screen now
	always_comb
	begin
		case (cur_kind)
			ground:                 choice_limit = 3'd2;
			two_block, three_block: choice_limit = 3'd4;
			default:                choice_limit = 3'd3;   // one_block and hole
		endcase
	end

	// Free running, stands in for a random source
	always_ff @(posedge CLOCK_50)
	begin
		if (!resetn)
			choice <= 3'd0;
		else if (choice >= choice_limit)
			choice <= 3'd0;
		else
			choice <= choice + 3'd1;
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (!resetn || new_game)
		begin
			cur_kind  <= ground;
			prev_kind <= ground;
		end
		else if (spawn_take)
		begin
			prev_kind <= cur_kind;
			cur_kind  <= placed_kind;
		end
	end

	// Transition table
	always_comb
	begin
		next_kind = ground;
		case (cur_kind)
			ground:
				case (choice)
					3'd1:    next_kind = hole;
					3'd2:    next_kind = one_block;
					default: next_kind = ground;
				endcase
			one_block:
				case (choice)
					3'd0:    next_kind = one_block;
					3'd2:    next_kind = hole;
					3'd3:    next_kind = two_block;
					default: next_kind = ground;
				endcase
			two_block, three_block:
				case (choice)
					3'd0:    next_kind = cur_kind;
					3'd2:    next_kind = hole;
					3'd3:    next_kind = one_block;
					3'd4:    next_kind = (cur_kind == two_block) ? three_block : two_block;
					default: next_kind = ground;
				endcase
			hole:   // Never climb above the kind before the hole
				case (choice)
					3'd0: next_kind = (prev_kind inside {one_block, two_block, three_block}) ?
						one_block : ground;
					3'd1: next_kind = (prev_kind inside {two_block, three_block}) ?
						two_block : ground;
					3'd2: next_kind = (prev_kind == three_block) ? three_block : ground;
					3'd3: next_kind = (prev_kind == hole) ? ground : prev_kind;
					default: next_kind = ground;
				endcase
			default: next_kind = ground;
		endcase
	end

endmodule

// File: verilog/runner_pkg.sv
package runner_pkg;

	// Terrain kinds placed on the track
	typedef enum logic [2:0] {
		ground,
		one_block,
		two_block,
		three_block,
		hole
	} terrain_t;

	typedef logic [7:0] coord_x_t;   // Screen column
	typedef logic [6:0] coord_y_t;   // Screen row, grows downward

	typedef struct packed {
		coord_y_t   char_y;
		coord_x_t   runner_x;
		logic [4:0] jump_count;
		logic       jumping;
		logic       dead;
	} runner_state_t;

	typedef struct packed {
		logic     spawned;   // A slot respawned this frame
		terrain_t kind;
		coord_y_t height;
	} spawn_t;

	// Most significant digit first, ones in the low nibble
	typedef struct packed {
		logic [3:0] hund_thou;
		logic [3:0] ten_thou;
		logic [3:0] thou;
		logic [3:0] hund;
		logic [3:0] ten;
		logic [3:0] one;
	} bcd_score_t;

	typedef struct packed {
		logic [6:0] hex5;
		logic [6:0] hex4;
		logic [6:0] hex3;
		logic [6:0] hex2;
		logic [6:0] hex1;
		logic [6:0] hex0;
	} hex_display_t;

	localparam int FRAME_TICKS  = 16;
	localparam int NUM_SLOTS    = 8;
	localparam int SLOT_SPACING = 20;

	localparam coord_x_t SPAWN_X  = 8'd180;
	localparam coord_x_t RUNNER_X = 8'd24;
	localparam coord_y_t START_Y  = 7'd98;

	// Top row of each terrain kind
	localparam coord_y_t HEIGHT_GROUND = 7'd100;
	localparam coord_y_t HEIGHT_ONE    = 7'd79;
	localparam coord_y_t HEIGHT_TWO    = 7'd59;
	localparam coord_y_t HEIGHT_THREE  = 7'd39;
	localparam coord_y_t HEIGHT_HOLE   = 7'd119;

	localparam logic [4:0] JUMP_LIMIT = 5'd30;
	localparam logic [4:0] JUMP_STEP  = 5'd2;
	localparam coord_y_t   RISE_STEP  = 7'd3;
	localparam coord_y_t   FALL_STEP  = 7'd2;

	// Active low segments, index is the digit
	localparam logic [9:0][6:0] SEG_DIGITS = {
		7'b001_1000,   // 9
		7'b000_0000,
		7'b111_1000,
		7'b000_0010,
		7'b001_0010,
		7'b001_1001,
		7'b011_0000,
		7'b010_0100,
		7'b111_1001,
		7'b100_0000    // 0
	};

endpackage
